//--- files.f
hdl/scurvePkg.sv
hdl/scurveTestControl.sv
hdl/slowControlLoader.sv
hdl/triggerWindowCounter.sv
hdl/triggerDataFifo.sv
hdl/scurveTestTop.sv
sim/scurveTestTb_assert.sv
sim/scurveTestTb.sv

//--- Makefile
TOP = scurveTestTb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f files.f -o Vsim
	./obj_dir/Vsim > sim.log 2>&1; status=$$?; cat sim.log; \
		test $$status -eq 0 && ! grep -q "Errors found" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- sim/scurveTestTb.sv
module scurveTestTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DacBits         = 3;
  localparam int WindowCycles    = 64;
  localparam int NumCodes        = 1 << DacBits;
  localparam int WordsPerChannel = 1 + 2 * NumCodes;  // Channel word, then DAC and count pairs
  localparam int ScParamBits     = 266;
  localparam int ClkPeriod       = 100;
  localparam logic [31:0] LfsrSeed = 32'h183;

  // Frame words of the output stream
  localparam logic [15:0] HeaderWord = 16'h5343;
  localparam logic [15:0] TailMark   = 16'hFF45;
  localparam logic [7:0]  AllTag     = 8'h63;
  localparam logic [7:0]  OneTag     = 8'h43;
  localparam logic [3:0]  CodeTag    = 4'hD;

  // Channels swept by all five tests
  localparam int TotalChannels = 1 + 1 + 64 + 1 + 1;
  localparam longint WatchdogCycles =
    longint'(TotalChannels) * NumCodes * (ScParamBits + WindowCycles + 120) + 2000;

  logic                 Clk = 1'b0;
  logic                 reset_n;
  logic                 testStart;
  scurvePkg::TestConfig scanConfig;
  logic                 trigger;
  logic                 windowOpen;
  logic                 scData;
  logic                 scShift;
  logic [15:0]          usbData;
  logic                 usbWrEn;
  logic                 usbFull = 1'b0;
  logic                 scanDone;
  logic                 transmitDone;

  logic                   randomFull = 1'b0;
  logic [31:0]            trigLfsr   = LfsrSeed;
  logic [31:0]            fullLfsr   = LfsrSeed;
  logic [ScParamBits-1:0] scCapture  = '0;
  int                     nValues[$];  // Trigger count per window
  int                     wordIndex  = 0;
  int                     openCycles = 0;
  int                     errorCount = 0;
  int                     testCount  = 0;
  int                     failedTests = 0;
  string                  testName   = "";

  always #(ClkPeriod / 2) Clk = ~Clk;

  scurveTestTop #(
    .DacBits(DacBits),
    .WindowCycles(WindowCycles)
  ) UUT (
    .Clk(Clk), .reset_n(reset_n),
    .testStart(testStart), .scanConfig(scanConfig),
    .trigger(trigger), .windowOpen(windowOpen),
    .scData(scData), .scShift(scShift),
    .usbData(usbData), .usbWrEn(usbWrEn), .usbFull(usbFull),
    .scanDone(scanDone), .transmitDone(transmitDone)
  );

  bind scurveTestTop scurveTestTb_assert controlChecks (
    .Clk(Clk), .reset_n(reset_n),
    .usbWrEn(usbWrEn), .usbFull(usbFull),
    .scLoad(scLoad), .configDone(configDone),
    .fifoFull(fifoFull),
    .scanDone(scanDone), .transmitDone(transmitDone)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic [15:0] expectedWord(input scurvePkg::TestConfig cfg, input int idx,
                                               input int nList[$]);
    int         numCh;
    int         block;
    int         pos;
    int         code;
    logic [5:0] ch;
    numCh = cfg.singleChannel ? 1 : 64;
    if (idx == 0) return HeaderWord;
    if (idx == 1 + numCh * WordsPerChannel) return TailMark;
    if (idx > 1 + numCh * WordsPerChannel) return 'x;  // Word past the tail
    block = (idx - 1) / WordsPerChannel;
    pos   = (idx - 1) % WordsPerChannel;
    ch    = cfg.singleChannel ? cfg.channel : 6'(block);
    if (pos == 0) return {cfg.singleChannel ? OneTag : AllTag, 2'b00, ch};
    code = (pos - 1) / 2;
    if (pos % 2 == 1) return {CodeTag, 2'b00, 10'(code)};
    if (block * NumCodes + code < nList.size()) return 16'(nList[block * NumCodes + code]);
    return 'x;
  endfunction

  // Last set of a scan, top code on the last channel
  function automatic logic [ScParamBits-1:0] expectedSet(input scurvePkg::TestConfig cfg);
    logic [63:0]  ctest;
    logic [9:0]   topCode;
    logic [9:0]   dacRev;
    logic [191:0] discri;
    logic [5:0]   ch;
    ch      = cfg.singleChannel ? cfg.channel : 6'd63;
    topCode = 10'(NumCodes - 1);
    ctest   = '0;
    discri  = '0;
    if (cfg.ctestInject) ctest[ch] = 1'b1;
    for (int i = 0; i < 10; i++) begin
      dacRev[9-i] = topCode[i];
    end
    for (int i = 0; i < 3; i++) begin
      discri[3*ch+i] = 1'b1;
    end
    return {ctest, dacRev, discri};
  endfunction

  //////////////////////////////////////////////////
  // ASIC and host models
  //////////////////////////////////////////////////
  initial begin : triggerModel
    int n;
    trigger = 1'b0;
    forever begin
      @(posedge windowOpen);
      n = 0;
      for (int b = 0; b < 3; b++) begin
        trigLfsr = lfsrNext(trigLfsr);
        n = (n << 1) | int'(trigLfsr[0]);
      end
      nValues.push_back(n);
      repeat (4) @(posedge Clk);
      repeat (n) begin
        trigger <= 1'b1;
        repeat (2) @(posedge Clk);
        trigger <= 1'b0;
        repeat (2) @(posedge Clk);
      end
    end
  end

  always @(posedge Clk) begin : fullModel
    if (randomFull) begin
      fullLfsr = lfsrNext(fullLfsr);
      usbFull <= fullLfsr[0];
    end else begin
      usbFull <= 1'b0;
    end
  end

  always @(posedge Clk) begin : captureSc
    if (scShift) scCapture <= {scCapture[ScParamBits-2:0], scData};  // MSB arrives first
  end

  // Length of each counting window
  always @(posedge Clk) begin : checkWindow
    if (!reset_n) begin
      openCycles = 0;
    end else if (windowOpen) begin
      openCycles++;
    end else if (openCycles != 0) begin
      assert (openCycles == WindowCycles) else begin
        errorCount++;
        $display("Fail %s window length: expected %0d, actual %0d", testName, WindowCycles,
                 openCycles);
      end
      openCycles = 0;
    end
  end

  always @(posedge Clk) begin : compareStream
    logic [15:0] expWord;
    if (reset_n && usbWrEn) begin
      expWord = expectedWord(scanConfig, wordIndex, nValues);
      assert (usbData === expWord) else begin
        errorCount++;
        $display("Fail %s word %0d: expected %h, actual %h", testName, wordIndex, expWord,
                 usbData);
      end
      assert (!usbFull) else begin
        errorCount++;
        $display("%s: word %0d was written while usbFull was high", testName, wordIndex);
      end
      wordIndex++;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  task automatic runScan(input string name, input logic single, input logic [5:0] ch,
                         input logic inject, input logic pressure);
    int errorsBefore;
    int totalWords;
    errorsBefore = errorCount;
    totalWords   = 2 + (single ? 1 : 64) * WordsPerChannel;
    testName     = name;
    trigLfsr     = LfsrSeed;  // Same counts in every run
    nValues.delete();
    wordIndex    = 0;
    scanConfig <= {single, ch, inject};
    randomFull <= pressure;
    @(posedge Clk);
    testStart <= 1'b1;
    while (!scanDone) @(posedge Clk);
    randomFull <= 1'b0;
    assert (wordIndex == totalWords) else begin
      errorCount++;
      $display("Fail %s word count: expected %0d, actual %0d", name, totalWords, wordIndex);
    end
    assert (scCapture === expectedSet(scanConfig)) else begin
      errorCount++;
      $display("Fail %s slow-control set: expected %h, actual %h", name,
               expectedSet(scanConfig), scCapture);
    end
    // Host takes its time before the acknowledge
    repeat (20) begin
      @(posedge Clk);
      assert (scanDone) else begin
        errorCount++;
        $display("%s: scanDone dropped before transmitDone", name);
      end
    end
    testStart    <= 1'b0;
    transmitDone <= 1'b1;
    @(posedge Clk);
    transmitDone <= 1'b0;
    @(posedge Clk);
    assert (!scanDone) else begin
      errorCount++;
      $display("%s: scanDone stayed high after transmitDone", name);
    end
    testCount++;
    if (errorCount == errorsBefore) begin
      $display("Test %s passed, %0d words", name, wordIndex);
    end else begin
      failedTests++;
      $display("Test %s failed with %0d mismatches", name, errorCount - errorsBefore);
    end
  endtask

  initial begin : mainSequence
    reset_n      = 1'b0;
    testStart    = 1'b0;
    scanConfig   = '0;
    transmitDone = 1'b0;
    repeat (10) @(posedge Clk);
    reset_n <= 1'b1;
    @(posedge Clk);
    runScan("single_ctest", 1'b1, 6'd37, 1'b1, 1'b0);
    runScan("single_pin", 1'b1, 6'd12, 1'b0, 1'b0);
    runScan("all_channels", 1'b0, 6'd0, 1'b1, 1'b0);
    runScan("backpressure", 1'b1, 6'd37, 1'b1, 1'b1);
    runScan("done_restart", 1'b1, 6'd37, 1'b1, 1'b0);  // Fresh header after the handshake
    $display("%0d tests, %0d failed, %0d mismatches", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: scan %s did not finish within %0d cycles", testName, WatchdogCycles);
    $display("Errors found");
    $finish;
  end

endmodule

//--- sim/scurveTestTb_assert.sv
module scurveTestTb_assert (
  input logic Clk,
  input logic reset_n,
  input logic usbWrEn,
  input logic usbFull,
  input logic scLoad,
  input logic configDone,
  input logic fifoFull,
  input logic scanDone,
  input logic transmitDone
);
  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////////////
  // Output strobe rules
  //////////////////////////////////////////////////
  singleWrite: assert property (@(posedge Clk) disable iff (!reset_n) usbWrEn |=> !usbWrEn)
    else $error("usbWrEn high for two cycles");

  noWriteWhenFull: assert property (@(posedge Clk) disable iff (!reset_n) usbWrEn |-> !usbFull)
    else $error("usbWrEn high while usbFull is high");

  // 266 shift cycles plus the load cycle
  loadLatency: assert property (@(posedge Clk) disable iff (!reset_n)
                                configDone |-> $past(scLoad, 267))
    else $error("configDone without a matching scLoad");

  // Each window is drained before the next one
  noFifoOverflow: assert property (@(posedge Clk) disable iff (!reset_n) !fifoFull)
    else $error("Trigger data FIFO full, count words would be dropped");

  doneHold: assert property (@(posedge Clk) disable iff (!reset_n)
                             scanDone && !transmitDone |=> scanDone)
    else $error("scanDone dropped before transmitDone");

endmodule

//--- hdl/scurveTestTop.sv
module scurveTestTop #(
  parameter int DacBits      = 10,
  parameter int WindowCycles = 4096,
  parameter int FifoDepth    = 16
) (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 testStart,
  input  scurvePkg::TestConfig scanConfig,
  input  logic                 trigger,
  output logic                 windowOpen,
  output logic                 scData,
  output logic                 scShift,
  output logic [15:0]          usbData,
  output logic                 usbWrEn,
  input  logic                 usbFull,
  output logic                 scanDone,
  input  logic                 transmitDone
);

  scurvePkg::ScParam scParam;
  logic        scLoad;
  logic        configDone;
  logic        windowStart;
  logic        windowDone;
  logic        fifoWrEn;
  logic [15:0] fifoWrData;
  logic        fifoRdEn;
  logic [15:0] fifoRdData;
  logic        fifoEmpty;
  logic        fifoFull;  // Watched by the bound checks

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////
  scurveTestControl #(
    .DacBits(DacBits)
  ) control (
    .Clk(Clk), .reset_n(reset_n),
    .testStart(testStart), .scanConfig(scanConfig),
    .scParam(scParam), .scLoad(scLoad), .configDone(configDone),
    .windowStart(windowStart), .windowDone(windowDone),
    .fifoEmpty(fifoEmpty), .fifoData(fifoRdData), .fifoRdEn(fifoRdEn),
    .usbData(usbData), .usbWrEn(usbWrEn), .usbFull(usbFull),
    .scanDone(scanDone), .transmitDone(transmitDone)
  );

  slowControlLoader loader (
    .Clk(Clk), .reset_n(reset_n),
    .scParam(scParam), .scLoad(scLoad),
    .scData(scData), .scShift(scShift), .configDone(configDone)
  );

  triggerWindowCounter #(
    .WindowCycles(WindowCycles)
  ) counter (
    .Clk(Clk), .reset_n(reset_n),
    .windowStart(windowStart), .trigger(trigger), .windowOpen(windowOpen),
    .fifoWrEn(fifoWrEn), .fifoWrData(fifoWrData), .windowDone(windowDone)
  );

  triggerDataFifo #(
    .FifoDepth(FifoDepth)
  ) dataFifo (
    .Clk(Clk), .reset_n(reset_n),
    .wrEn(fifoWrEn), .wrData(fifoWrData),
    .rdEn(fifoRdEn), .rdData(fifoRdData),
    .empty(fifoEmpty), .full(fifoFull)
  );

endmodule

//--- hdl/triggerDataFifo.sv
module triggerDataFifo #(
  parameter int FifoDepth = 16
) (
  input  logic        Clk,
  input  logic        reset_n,
  input  logic        wrEn,
  input  logic [15:0] wrData,
  input  logic        rdEn,
  output logic [15:0] rdData,
  output logic        empty,
  output logic        full
);

  localparam int AddrBits = $clog2(FifoDepth);

  logic [15:0]       mem [FifoDepth];
  logic [AddrBits:0] wrPtr;  // Extra bit tells full from empty
  logic [AddrBits:0] rdPtr;

  assign empty = (wrPtr == rdPtr);
  assign full  = (wrPtr[AddrBits-1:0] == rdPtr[AddrBits-1:0]) &&
                 (wrPtr[AddrBits] != rdPtr[AddrBits]);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (wrEn && !full) wrPtr <= wrPtr + 1'b1;  // Drop when full
      if (rdEn && !empty) rdPtr <= rdPtr + 1'b1;
    end
  end

  // Storage and registered read port
  always_ff @(posedge Clk) begin
    if (wrEn && !full) mem[wrPtr[AddrBits-1:0]] <= wrData;
    if (rdEn && !empty) rdData <= mem[rdPtr[AddrBits-1:0]];
  end

endmodule

//--- hdl/triggerWindowCounter.sv
module triggerWindowCounter #(
  parameter int WindowCycles = 4096
) (
  input  logic        Clk,
  input  logic        reset_n,
  input  logic        windowStart,
  input  logic        trigger,
  output logic        windowOpen,
  output logic        fifoWrEn,
  output logic [15:0] fifoWrData,
  output logic        windowDone
);

  localparam int CycleBits = $clog2(WindowCycles + 1);

  logic [1:0]           trigSync;   // Two-flop synchronizer
  logic                 trigPrev;
  logic                 trigRise;
  logic [CycleBits-1:0] cycleCount;
  logic [15:0]          hitCount;
  logic [15:0]          hitNext;
  logic                 lastCycle;

  assign trigRise  = trigSync[1] & ~trigPrev;
  assign hitNext   = (trigRise && hitCount != 16'hFFFF) ? hitCount + 1'b1 : hitCount;
  assign lastCycle = (cycleCount == CycleBits'(WindowCycles - 1));

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      trigSync   <= '0;
      trigPrev   <= 1'b0;
      windowOpen <= 1'b0;
      cycleCount <= '0;
      hitCount   <= '0;
      fifoWrEn   <= 1'b0;
      windowDone <= 1'b0;
    end else begin
      trigSync   <= {trigSync[0], trigger};
      trigPrev   <= trigSync[1];
      windowDone <= fifoWrEn;  // One cycle after the count is written
      fifoWrEn   <= 1'b0;
      if (windowStart) begin
        windowOpen <= 1'b1;
        cycleCount <= '0;
        hitCount   <= '0;
      end else if (windowOpen) begin
        hitCount   <= hitNext;  // Saturates at full scale
        cycleCount <= cycleCount + 1'b1;
        if (lastCycle) begin
          windowOpen <= 1'b0;
          fifoWrEn   <= 1'b1;
        end
      end
    end
  end

  // Count word includes an edge seen in the last cycle
  always_ff @(posedge Clk) begin
    if (windowOpen && lastCycle) fifoWrData <= hitNext;
  end

endmodule

//--- hdl/slowControlLoader.sv
module slowControlLoader (
  input  logic              Clk,
  input  logic              reset_n,
  input  scurvePkg::ScParam scParam,
  input  logic              scLoad,
  output logic              scData,
  output logic              scShift,
  output logic              configDone
);

  localparam int ParamBits = $bits(scurvePkg::ScParam);
  localparam int CountBits = $clog2(ParamBits + 1);

  logic [ParamBits-1:0] shiftReg;
  logic [CountBits-1:0] bitsLeft;
  logic                 lastBit;

  assign lastBit = (bitsLeft == CountBits'(1));

  // MSB of the set leads the chain
  assign scData = scShift & shiftReg[ParamBits-1];

  //////////////////////////////////////////////////
  // Shift control
  //////////////////////////////////////////////////
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      bitsLeft   <= '0;
      scShift    <= 1'b0;
      configDone <= 1'b0;
    end else begin
      configDone <= 1'b0;
      if (scLoad) begin
        bitsLeft <= CountBits'(ParamBits);
        scShift  <= 1'b1;
      end else if (scShift) begin
        bitsLeft <= bitsLeft - 1'b1;
        if (lastBit) begin
          scShift    <= 1'b0;
          configDone <= 1'b1;  // Chain fully loaded
        end
      end
    end
  end

  // Parameter shift register
  always_ff @(posedge Clk) begin
    if (scLoad) begin
      shiftReg <= scParam;
    end else if (scShift) begin
      shiftReg <= {shiftReg[ParamBits-2:0], 1'b0};
    end
  end

endmodule

//--- hdl/scurveTestControl.sv
module scurveTestControl #(
  parameter int DacBits = 10
) (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 testStart,
  input  scurvePkg::TestConfig scanConfig,
  output scurvePkg::ScParam    scParam,
  output logic                 scLoad,
  input  logic                 configDone,
  output logic                 windowStart,
  input  logic                 windowDone,
  input  logic                 fifoEmpty,
  input  logic [15:0]          fifoData,
  output logic                 fifoRdEn,
  output logic [15:0]          usbData,
  output logic                 usbWrEn,
  input  logic                 usbFull,
  output logic                 scanDone,
  input  logic                 transmitDone
);

  localparam logic [DacBits-1:0] TopCode = '1;
  localparam logic [5:0] LastChannel = 6'(scurvePkg::NumChannels - 1);

  scurvePkg::ControlState state;
  logic [5:0]         channel;
  logic [DacBits-1:0] dacCode;
  logic [9:0]         dacCodeWide;
  logic [7:0]         discriSlot;
  logic               wordState;

  // DAC code enters the chain LSB first
  function automatic logic [9:0] bitReverse(input logic [9:0] code);
    logic [9:0] rev;
    for (int i = 0; i < 10; i++) begin
      rev[i] = code[9-i];
    end
    return rev;
  endfunction

  assign dacCodeWide = 10'(dacCode);
  assign discriSlot  = 8'(channel) * 8'd3;

  // States that hold a word for the output FIFO
  assign wordState = state inside {scurvePkg::StHeader, scurvePkg::StChanWord,
                                   scurvePkg::StDacWord, scurvePkg::StWriteWord,
                                   scurvePkg::StTail};

  assign usbWrEn     = wordState && !usbFull;  // Stall while full
  assign scLoad      = (state == scurvePkg::StLoad);
  assign windowStart = (state == scurvePkg::StStartWindow);
  assign fifoRdEn    = (state == scurvePkg::StReadFifo) && !fifoEmpty;

  //////////////////////////////////////////////////
  // Channel and code loops
  //////////////////////////////////////////////////
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state    <= scurvePkg::StIdle;
      channel  <= '0;
      dacCode  <= '0;
      scanDone <= 1'b0;
    end else begin
      case (state)
        scurvePkg::StIdle: begin
          if (testStart) begin
            channel <= scanConfig.singleChannel ? scanConfig.channel : 6'd0;
            dacCode <= '0;
            state   <= scurvePkg::StHeader;
          end
        end
        scurvePkg::StHeader: begin
          if (!usbFull) state <= scurvePkg::StChanSetup;
        end
        scurvePkg::StChanSetup:  state <= scurvePkg::StChanWord;
        scurvePkg::StChanWord: begin
          if (!usbFull) state <= scurvePkg::StDacSetup;
        end
        scurvePkg::StDacSetup:   state <= scurvePkg::StDacWord;
        scurvePkg::StDacWord: begin
          if (!usbFull) state <= scurvePkg::StLoad;
        end
        scurvePkg::StLoad:       state <= scurvePkg::StWaitLoad;
        scurvePkg::StWaitLoad: begin
          if (configDone) state <= scurvePkg::StStartWindow;
        end
        scurvePkg::StStartWindow: state <= scurvePkg::StWaitWindow;
        scurvePkg::StWaitWindow: begin
          if (windowDone) state <= scurvePkg::StReadFifo;
        end
        scurvePkg::StReadFifo: begin
          // Drain every count word of the window
          state <= fifoEmpty ? scurvePkg::StNextCode : scurvePkg::StFetchWord;
        end
        scurvePkg::StFetchWord:  state <= scurvePkg::StWriteWord;
        scurvePkg::StWriteWord: begin
          if (!usbFull) state <= scurvePkg::StReadFifo;
        end
        scurvePkg::StNextCode: begin
          if (dacCode == TopCode) begin
            dacCode <= '0;
            state   <= scurvePkg::StNextChannel;
          end else begin
            dacCode <= dacCode + 1'b1;
            state   <= scurvePkg::StDacSetup;
          end
        end
        scurvePkg::StNextChannel: begin
          if (scanConfig.singleChannel || channel == LastChannel) begin
            state <= scurvePkg::StTail;
          end else begin
            channel <= channel + 1'b1;
            state   <= scurvePkg::StChanSetup;
          end
        end
        scurvePkg::StTail: begin
          if (!usbFull) begin
            scanDone <= 1'b1;
            state    <= scurvePkg::StDoneHold;
          end
        end
        scurvePkg::StDoneHold: begin
          if (transmitDone) scanDone <= 1'b0;  // Host has the data
          if ((transmitDone || !scanDone) && !testStart) state <= scurvePkg::StIdle;
        end
        default: state <= scurvePkg::StIdle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Output word and slow-control set
  //////////////////////////////////////////////////
  always_ff @(posedge Clk) begin
    case (state)
      scurvePkg::StIdle: usbData <= scurvePkg::ScanHeader;
      scurvePkg::StChanSetup: begin
        scParam.ctestMask  <= scanConfig.ctestInject ? (64'd1 << channel) : 64'd0;
        scParam.discriMask <= 192'h7 << discriSlot;  // Three ones at the slot
        usbData <= {scanConfig.singleChannel ? scurvePkg::SingleTag : scurvePkg::ChannelTag,
                    2'b00, channel};
      end
      scurvePkg::StDacSetup: begin
        scParam.dacCode <= bitReverse(dacCodeWide);
        usbData         <= {scurvePkg::DacTag, 2'b00, dacCodeWide};
      end
      scurvePkg::StFetchWord:   usbData <= fifoData;  // Count from the data FIFO
      scurvePkg::StNextChannel: usbData <= scurvePkg::TailWord;
      default: ;
    endcase
  end

endmodule

//--- hdl/scurvePkg.sv
package scurvePkg;

  localparam int NumChannels = 64;  // Fixed by the ASIC

  //////////////////////////////////////////////////
  // Frame words of the output stream
  //////////////////////////////////////////////////
  localparam logic [15:0] ScanHeader = 16'h5343;  // "SC"
  localparam logic [15:0] TailWord   = 16'hFF45;
  localparam logic [7:0]  ChannelTag = 8'h63;     // "c", 64-channel scan
  localparam logic [7:0]  SingleTag  = 8'h43;     // "C", single channel scan
  localparam logic [3:0]  DacTag     = 4'hD;

  // Sequencer states
  typedef enum logic [4:0] {
    StIdle,
    StHeader,
    StChanSetup,
    StChanWord,
    StDacSetup,
    StDacWord,
    StLoad,
    StWaitLoad,
    StStartWindow,
    StWaitWindow,
    StReadFifo,
    StFetchWord,
    StWriteWord,
    StNextCode,
    StNextChannel,
    StTail,
    StDoneHold
  } ControlState;

  // Slow-control set, shifted MSB first
  typedef struct packed {
    logic [NumChannels-1:0]   ctestMask;
    logic [9:0]               dacCode;     // Already bit-reversed
    logic [3*NumChannels-1:0] discriMask;  // Three bits per channel
  } ScParam;

  typedef struct packed {
    logic       singleChannel;
    logic [5:0] channel;
    logic       ctestInject;  // Low selects the input pin
  } TestConfig;

endpackage
